// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_term_core
FILELIST  ?= verilog.f
BUILD     ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove the $(BUILD) build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: common/term_pkg.sv
package term_pkg;

    typedef logic [7:0] char_t;    // One byte off the serial line

    // Control codes the terminal acts on
    localparam char_t CH_BEL   = 8'h07;
    localparam char_t CH_BS    = 8'h08;
    localparam char_t CH_LF    = 8'h0A;
    localparam char_t CH_FF    = 8'h0C;
    localparam char_t CH_CR    = 8'h0D;
    localparam char_t CH_SPACE = 8'h20;   // Blank cell
    localparam char_t CH_DEL   = 8'h7F;

    // Glyphs the font has
    localparam char_t CH_PRINT_LO = 8'h20;
    localparam char_t CH_PRINT_HI = 8'h7E;

    // What the controller does with a byte
    typedef enum logic [2:0] {
        CC_PRINT,      // Written at the cursor
        CC_CR,
        CC_LF,
        CC_BS,
        CC_BEL,
        CC_FF,
        CC_OTHER_CTL,  // Below 0x20, glyph only with ectl set
        CC_DEL         // DEL and the upper half, dropped
    } char_class_e;

endpackage

// File: common/term_settings.svh
`ifndef TERM_SETTINGS_SVH
`define TERM_SETTINGS_SVH

// Visible screen, in characters
`define TERM_COLS 64           // Fills the 6-bit column field
`define TERM_ROWS 17           // At most 32 with a 5-bit row field

// Bell flash length in clocks
`define BELL_CYCLES 1200

// Clocks a button level must hold before it counts
`define BTN_DEBOUNCE 1000

// 12 MHz / 115200 baud
`define UART_CLKS_PER_BIT 104

`endif

// File: common/vram_pkg.sv
package vram_pkg;

    // Screen position, row above column
    typedef struct packed {
        logic [4:0] row;
        logic [5:0] col;
    } vram_rc_s;

    // Same 11 bits, seen as a cell or as a memory index
    typedef union packed {
        vram_rc_s    rc;
        logic [10:0] flat;
    } vram_addr_u;

    // Controller side of the memory, 21 bits
    typedef struct packed {
        vram_addr_u  addr;
        logic [7:0]  wdata;   // One character
        logic        en;      // Access this cycle
        logic        we;      // Write when set, else read
    } vram_port_s;

endpackage

// File: control/scroll_engine.sv
`include "term_settings.svh"

module scroll_engine
    import term_pkg::*;
    import vram_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_start,   // One-cycle request
    input  logic       i_clear,   // Fill whole screen, no copy
    output vram_port_s o_port,
    input  char_t      i_rdata,
    output logic       o_done     // Pulse after the last fill write
);
    localparam logic [4:0] LAST_ROW = 5'(`TERM_ROWS - 1);
    localparam logic [4:0] LAST_SRC = 5'(`TERM_ROWS - 2);   // Last row that receives a copy
    localparam logic [5:0] LAST_COL = 6'(`TERM_COLS - 1);

    typedef enum logic [1:0] {SE_IDLE, SE_READ, SE_WRITE, SE_FILL} se_state_e;

    se_state_e  state;
    logic [4:0] row;   // Destination row
    logic [5:0] col;
    logic       end_col;

    assign end_col = (col == LAST_COL);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state  <= SE_IDLE;
            row    <= '0;
            col    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                SE_IDLE: if (i_start) begin
                    row   <= '0;
                    col   <= '0;
                    state <= i_clear ? SE_FILL : SE_READ;
                end
                SE_READ: state <= SE_WRITE;            // Cell below arrives next clock
                SE_WRITE: begin
                    col   <= col + 6'd1;
                    state <= SE_READ;
                    if (end_col) begin
                        col <= '0;
                        row <= row + 5'd1;             // After the copy this is the last row
                        if (row == LAST_SRC) state <= SE_FILL;
                    end
                end
                SE_FILL: begin
                    col <= col + 6'd1;
                    if (end_col) begin
                        col <= '0;
                        if (row == LAST_ROW) begin
                            state  <= SE_IDLE;
                            o_done <= 1'b1;
                        end else begin
                            row <= row + 5'd1;
                        end
                    end
                end
                default: state <= SE_IDLE;
            endcase
        end
    end

    always_comb begin
        o_port             = '0;
        o_port.addr.rc.col = col;
        o_port.addr.rc.row = (state == SE_READ) ? row + 5'd1 : row;  // Source is one row down
        o_port.wdata       = (state == SE_FILL) ? CH_SPACE : i_rdata;
        o_port.en          = (state != SE_IDLE);
        o_port.we          = (state == SE_WRITE) || (state == SE_FILL);
    end

endmodule

// File: control/term_control.sv
`include "term_settings.svh"

module term_control
    import term_pkg::*;
    import vram_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  char_t      i_data,
    input  logic       i_valid,
    output logic       o_ready,
    input  logic       i_ectl,          // Show other control codes as glyphs
    output vram_port_s o_port,          // To VRAM, after the owner mux
    input  char_t      i_rdata,
    input  vram_port_s i_scroll_port,   // Scroll engine's request
    output logic       o_scroll_start,
    output logic       o_scroll_clear,
    input  logic       i_scroll_done,
    output vram_addr_u o_cursor,
    output logic       o_bel
);
    localparam logic [4:0] LAST_ROW = 5'(`TERM_ROWS - 1);
    localparam logic [5:0] LAST_COL = 6'(`TERM_COLS - 1);
    localparam int BW = $clog2(`BELL_CYCLES + 1);

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_START, ST_WAIT} ctl_state_e;

    function automatic char_class_e classify(char_t c);
        char_class_e k;
        case (c)
            CH_CR:   k = CC_CR;
            CH_LF:   k = CC_LF;
            CH_BS:   k = CC_BS;
            CH_BEL:  k = CC_BEL;
            CH_FF:   k = CC_FF;
            default: begin
                if (c < CH_PRINT_LO) k = CC_OTHER_CTL;
                else if (c > CH_PRINT_HI) k = CC_DEL;   // DEL and above, no glyph
                else k = CC_PRINT;
            end
        endcase
        return k;
    endfunction

    ctl_state_e    state;
    vram_addr_u    cursor;
    char_t         char_q;    // Byte waiting for its write
    logic          clear_q;   // Next engine run is a clear
    logic [BW-1:0] bel_cnt;
    char_class_e   cls;
    logic          accept;
    logic          last_row;
    logic          scroll_owns;
    vram_port_s    own_port;

    assign o_ready        = (state == ST_IDLE);
    assign accept         = i_valid && o_ready;
    assign cls            = classify(i_data);
    assign last_row       = (cursor.rc.row == LAST_ROW);
    assign scroll_owns    = (state == ST_WAIT);   // Start pulse to done
    assign o_scroll_start = (state == ST_START);
    assign o_scroll_clear = clear_q;
    assign o_cursor       = cursor;
    assign o_bel          = (bel_cnt != '0);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= ST_START;   // Clear the screen first
            clear_q <= 1'b1;
            cursor  <= '0;
            bel_cnt <= '0;
        end else begin
            if (bel_cnt != '0) bel_cnt <= bel_cnt - 1'b1;
            case (state)
                ST_IDLE: if (accept) begin
                    case (cls)
                        CC_PRINT:     state <= ST_WRITE;
                        CC_OTHER_CTL: if (i_ectl) state <= ST_WRITE;
                        CC_CR:        cursor.rc.col <= '0;
                        CC_LF: begin
                            if (last_row) begin
                                state   <= ST_START;   // Scroll, stay on last row
                                clear_q <= 1'b0;
                            end else begin
                                cursor.rc.row <= cursor.rc.row + 5'd1;
                            end
                        end
                        CC_BS: if (cursor.rc.col != '0) cursor.rc.col <= cursor.rc.col - 6'd1;
                        CC_BEL:       bel_cnt <= BW'(`BELL_CYCLES);   // Retriggers
                        CC_FF: begin
                            cursor  <= '0;
                            state   <= ST_START;
                            clear_q <= 1'b1;
                        end
                        default: ;   // Dropped
                    endcase
                end
                ST_WRITE: begin
                    state         <= ST_IDLE;
                    cursor.rc.col <= cursor.rc.col + 6'd1;
                    if (cursor.rc.col == LAST_COL) begin
                        cursor.rc.col <= '0;   // Wrap to next row
                        if (last_row) begin
                            state   <= ST_START;
                            clear_q <= 1'b0;
                        end else begin
                            cursor.rc.row <= cursor.rc.row + 5'd1;
                        end
                    end
                end
                ST_START: state <= ST_WAIT;
                ST_WAIT:  if (i_scroll_done) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) char_q <= i_data;
    end

    always_comb begin
        own_port       = '0;
        own_port.addr  = cursor;   // Cursor still points at the cell being written
        own_port.wdata = char_q;
        own_port.en    = (state == ST_WRITE);
        own_port.we    = (state == ST_WRITE);
    end

    assign o_port = scroll_owns ? i_scroll_port : own_port;

    cursor_in_range: assert property (@(posedge i_clk) disable iff (i_rst)
        cursor.rc.row <= LAST_ROW);

endmodule

// File: logic/btn_toggle.sv
`include "term_settings.svh"

module btn_toggle (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_btn,   // Raw, bouncing
    output logic o_sw     // Flips on each press
);
    localparam int CW = $clog2(`BTN_DEBOUNCE);
    localparam logic [CW-1:0] LAST_CNT = CW'(`BTN_DEBOUNCE - 1);

    logic [1:0]    sync;
    logic [CW-1:0] cnt;      // Clocks the new level has held
    logic          stable;   // Accepted button level

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sync   <= '0;
            cnt    <= '0;
            stable <= 1'b0;
            o_sw   <= 1'b0;
        end else begin
            sync <= {sync[0], i_btn};
            if (sync[1] == stable) begin
                cnt <= '0;                      // Bounce back restarts the wait
            end else if (cnt == LAST_CNT) begin
                cnt    <= '0;
                stable <= sync[1];
                if (sync[1]) o_sw <= ~o_sw;     // Press, not release
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/term_core.sv
`include "term_settings.svh"

module term_core
    import term_pkg::*;
    import vram_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_rxd,         // From the PC
    input  logic       i_btn,         // Control glyph toggle
    input  vram_addr_u i_scan_addr,   // Renderer read port
    output char_t      o_scan_data,
    output vram_addr_u o_cursor,
    output logic       o_bel,
    output logic       o_ectl,
    output logic       o_overrun
);
    char_t      rx_data;
    logic       rx_valid;
    logic       rx_ready;
    vram_port_s vram_port;     // After the owner mux
    vram_port_s scroll_port;
    char_t      vram_rdata;
    logic       scroll_start;
    logic       scroll_clear;
    logic       scroll_done;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rxd     (i_rxd),
        .o_data    (rx_data),
        .o_valid   (rx_valid),
        .i_ready   (rx_ready),
        .o_overrun (o_overrun)
    );

    btn_toggle u_btn_ectl (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_btn (i_btn),
        .o_sw  (o_ectl)
    );

    term_control u_control (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_data         (rx_data),
        .i_valid        (rx_valid),
        .o_ready        (rx_ready),
        .i_ectl         (o_ectl),
        .o_port         (vram_port),
        .i_rdata        (vram_rdata),
        .i_scroll_port  (scroll_port),
        .o_scroll_start (scroll_start),
        .o_scroll_clear (scroll_clear),
        .i_scroll_done  (scroll_done),
        .o_cursor       (o_cursor),
        .o_bel          (o_bel)
    );

    scroll_engine u_scroll (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (scroll_start),
        .i_clear (scroll_clear),
        .o_port  (scroll_port),
        .i_rdata (vram_rdata),
        .o_done  (scroll_done)
    );

    vram u_vram (
        .i_clk       (i_clk),
        .i_port      (vram_port),
        .o_rdata     (vram_rdata),
        .i_scan_addr (i_scan_addr),
        .o_scan_data (o_scan_data)
    );

endmodule

// File: tests/tb_term_core.sv
`include "term_settings.svh"

module tb_term_core
    import term_pkg::*;
    import vram_pkg::*;
();
    localparam int CPB  = 8;                // Serial bit period in clocks
    localparam int ROWS = `TERM_ROWS;
    localparam int COLS = `TERM_COLS;

    // Run length bounds for the watchdog
    localparam int BYTE_CLKS     = 12 * CPB + 8;   // Frame, idle gap, handshake
    localparam int SCROLL_CLKS   = (ROWS - 1) * COLS * 2 + COLS + 8;
    localparam int SWEEP_CLKS    = ROWS * COLS + 4;
    localparam int MAX_BYTES     = 220;
    localparam int MAX_SCROLLS   = 12;
    localparam int MAX_SWEEPS    = 10;
    localparam int READY_LIMIT   = SCROLL_CLKS + 64;
    localparam int WATCHDOG_CLKS = MAX_BYTES * BYTE_CLKS + MAX_SCROLLS * SCROLL_CLKS
                                 + MAX_SWEEPS * SWEEP_CLKS + `BELL_CYCLES
                                 + 3 * `BTN_DEBOUNCE + 2000;

    logic       clk;
    logic       rst;
    logic       rxd;
    logic       btn;
    vram_addr_u scan_addr;
    char_t      scan_data;
    vram_addr_u cursor;
    logic       bel;
    logic       ectl;
    logic       overrun;

    char_t       shadow [0:ROWS-1][0:COLS-1];   // Expected screen
    int          cur_r;
    int          cur_c;
    logic        bel_exp;
    logic        ectl_exp;
    logic [15:0] lfsr;

    logic        chk_on;      // Cursor and levels checked next edge
    logic [10:0] exp_cur;
    logic        scan_chk;    // Scan data checked next edge
    char_t       scan_exp;
    logic [10:0] scan_at;     // Address of the read under check
    int          bel_len;     // Clocks o_bel has been high
    int          bell_pulses;
    int          scan_errs;
    int          state_errs;
    int          other_errs;

    term_core #(
        .CLKS_PER_BIT (CPB)
    ) DUT (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_rxd       (rxd),
        .i_btn       (btn),
        .i_scan_addr (scan_addr),
        .o_scan_data (scan_data),
        .o_cursor    (cursor),
        .o_bel       (bel),
        .o_ectl      (ectl),
        .o_overrun   (overrun)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    cursor_match: assert property (@(posedge clk) disable iff (rst)
        chk_on |-> cursor.flat == exp_cur)
        else begin
            state_errs++;
            $display("error o_cursor: got %h expected %h", cursor.flat, exp_cur);
        end

    bel_level: assert property (@(posedge clk) disable iff (rst) chk_on |-> bel == bel_exp)
        else begin
            state_errs++;
            $display("error o_bel: got %h expected %h", bel, bel_exp);
        end

    ectl_level: assert property (@(posedge clk) disable iff (rst) chk_on |-> ectl == ectl_exp)
        else begin
            state_errs++;
            $display("error o_ectl: got %h expected %h", ectl, ectl_exp);
        end

    scan_match: assert property (@(posedge clk) disable iff (rst)
        scan_chk |-> scan_data == scan_exp)
        else begin
            scan_errs++;
            $display("error o_scan_data at %h: got %h expected %h",
                     scan_at, scan_data, scan_exp);
        end

    // Outputs settle between edges, so look at them here
    always @(negedge clk) begin
        if (!rst) begin
            no_overrun: assert (!overrun) else begin
                other_errs++;
                $display("receiver overran and dropped a byte");
            end
            if (bel) begin
                bel_len++;
            end else if (bel_len != 0) begin   // Bell just ended
                bell_length: assert (bel_len == `BELL_CYCLES) else begin
                    other_errs++;
                    $display("error o_bel length: got %h expected %h", bel_len, `BELL_CYCLES);
                end
                bell_pulses++;
                bel_len = 0;
            end
        end
    end

    // Taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[15]};   // One step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic rand_printable(output char_t c);
        logic [7:0] v;
        take_bits(7, v);
        c = char_t'(v % 8'd95) + CH_PRINT_LO;   // 0x20..0x7E
    endtask

    task automatic clear_shadow();
        int r;
        int c;
        for (r = 0; r < ROWS; r++) begin
            for (c = 0; c < COLS; c++) begin
                shadow[r][c] = CH_SPACE;
            end
        end
    endtask

    task automatic scroll_shadow();
        int r;
        int c;
        for (r = 0; r < ROWS - 1; r++) begin
            for (c = 0; c < COLS; c++) begin
                shadow[r][c] = shadow[r+1][c];
            end
        end
        for (c = 0; c < COLS; c++) begin
            shadow[ROWS-1][c] = CH_SPACE;
        end
    endtask

    task automatic advance_row();
        if (cur_r == ROWS - 1) begin
            scroll_shadow();   // Cursor stays on the bottom row
        end else begin
            cur_r++;
        end
    endtask

    task automatic put_char(input char_t b);
        shadow[cur_r][cur_c] = b;
        cur_c++;
        if (cur_c == COLS) begin
            cur_c = 0;
            advance_row();
        end
    endtask

    // Terminal rules applied to the expected screen
    task automatic model_byte(input char_t b);
        if (b == CH_CR) begin
            cur_c = 0;
        end else if (b == CH_LF) begin
            advance_row();
        end else if (b == CH_BS) begin
            if (cur_c > 0) cur_c--;   // Stops at column 0
        end else if (b == CH_BEL) begin
            bel_exp = 1'b1;
        end else if (b == CH_FF) begin
            clear_shadow();
            cur_r = 0;
            cur_c = 0;
        end else if (b >= CH_PRINT_LO && b <= CH_PRINT_HI) begin
            put_char(b);
        end else if (b < CH_PRINT_LO && ectl_exp) begin
            put_char(b);   // Control glyph
        end
    endtask

    // 8N1, LSB first
    task automatic send_serial(input char_t b);
        int i;
        rxd = 1'b0;
        repeat (CPB) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            rxd = b[i];
            repeat (CPB) @(negedge clk);
        end
        rxd = 1'b1;
        repeat (CPB) @(negedge clk);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!(DUT.rx_ready && !DUT.rx_valid) && n < READY_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= READY_LIMIT) begin
            other_errs++;
            $display("controller did not return to idle within %0d clocks", READY_LIMIT);
        end
    endtask

    task automatic check_state();
        exp_cur = {5'(cur_r), 6'(cur_c)};
        chk_on  = 1'b1;
        @(negedge clk);
        chk_on  = 1'b0;
    endtask

    task automatic send_byte(input char_t b);
        model_byte(b);
        send_serial(b);
        repeat (2 * CPB) @(negedge clk);   // Byte surely handed over
        wait_ready();
        check_state();
    endtask

    // New address every clock, each read checked one clock later
    task automatic sweep_screen();
        int r;
        int c;
        for (r = 0; r < ROWS; r++) begin
            for (c = 0; c < COLS; c++) begin
                scan_addr.rc.row = 5'(r);
                scan_addr.rc.col = 6'(c);
                @(negedge clk);
                scan_at  = {5'(r), 6'(c)};
                scan_exp = shadow[r][c];   // Registered on the edge just passed
                scan_chk = 1'b1;
            end
        end
        @(negedge clk);
        scan_chk = 1'b0;
    endtask

    task automatic press_button();
        btn = 1'b1;
        repeat (20) @(negedge clk);   // Bounce, far shorter than the debounce
        btn = 1'b0;
        repeat (20) @(negedge clk);
        btn = 1'b1;
        repeat (`BTN_DEBOUNCE + 20) @(negedge clk);
        btn = 1'b0;
        repeat (`BTN_DEBOUNCE + 20) @(negedge clk);
    endtask

    task automatic wait_bell_end();
        int n;
        n = 0;
        while (bel && n < `BELL_CYCLES + 100) begin
            @(negedge clk);
            n++;
        end
        if (bel) begin
            other_errs++;
            $display("bell stayed on far past its length");
        end
        bel_exp = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("watchdog expired after %0d clocks, run did not finish", WATCHDOG_CLKS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int i;
        int k;
        char_t c;
        rst         = 1'b1;
        rxd         = 1'b1;   // Line idle
        btn         = 1'b0;
        scan_addr   = '0;
        chk_on      = 1'b0;
        exp_cur     = '0;
        scan_chk    = 1'b0;
        scan_exp    = CH_SPACE;
        scan_at     = '0;
        bel_len     = 0;
        bell_pulses = 0;
        scan_errs   = 0;
        state_errs  = 0;
        other_errs  = 0;
        cur_r       = 0;
        cur_c       = 0;
        bel_exp     = 1'b0;
        ectl_exp    = 1'b0;
        lfsr        = 16'd97;
        clear_shadow();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        wait_ready();   // Power-up clear
        check_state();
        sweep_screen();

        for (i = 0; i < 80; i++) begin   // Wraps past column 63
            rand_printable(c);
            send_byte(c);
        end
        sweep_screen();

        send_byte(CH_BS);
        send_byte(CH_BS);
        send_byte(CH_BS);
        send_byte(CH_CR);
        send_byte(CH_BS);   // Already at column 0
        rand_printable(c);
        send_byte(c);
        rand_printable(c);
        send_byte(c);
        send_byte(CH_LF);
        send_byte(CH_CR);
        sweep_screen();

        for (i = 0; i < 20; i++) begin   // Last few lines scroll
            for (k = 0; k < 3; k++) begin
                rand_printable(c);
                send_byte(c);
            end
            send_byte(CH_CR);
            send_byte(CH_LF);
        end
        sweep_screen();

        send_byte(CH_BEL);
        wait_bell_end();
        check_state();
        send_byte(CH_FF);
        sweep_screen();

        send_byte(8'h01);   // ectl low, dropped
        sweep_screen();
        press_button();
        ectl_exp = 1'b1;
        check_state();
        send_byte(8'h01);
        sweep_screen();

        if (bell_pulses != 1) begin
            other_errs++;
            $display("expected one bell pulse but saw %0d", bell_pulses);
        end
        $display("errors: scan %0d, cursor and levels %0d, other %0d",
                 scan_errs, state_errs, other_errs);
        if (scan_errs + state_errs + other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: uart/uart_rx.sv
`include "term_settings.svh"

module uart_rx
    import term_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_rxd,      // Serial line, idles high
    output char_t o_data,
    output logic  o_valid,
    input  logic  i_ready,
    output logic  o_overrun   // Byte lost, one-cycle pulse
);
    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] LAST_CLK = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_CLK = CW'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e     state;
    logic [1:0]    rx_sync;   // Two-flop synchronizer
    logic          rxd_s;
    logic [CW-1:0] cnt;       // Clocks into the current bit
    logic [2:0]    bit_idx;
    char_t         shift;     // LSB first
    logic          stop_ok;

    assign rxd_s   = rx_sync[1];
    assign stop_ok = (state == RX_STOP) && (cnt == LAST_CLK) && rxd_s;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            rx_sync <= 2'b11;
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            rx_sync <= {rx_sync[0], i_rxd};
            cnt     <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rxd_s) state <= RX_START;    // Falling edge of start bit
                end
                RX_START: if (cnt == HALF_CLK) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rxd_s ? RX_IDLE : RX_DATA;  // Glitch goes back to idle
                end
                RX_DATA: if (cnt == LAST_CLK) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (cnt == LAST_CLK) state <= RX_IDLE;  // Mid stop bit
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Mid-bit sampling of data bits
    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && cnt == LAST_CLK) shift <= {rxd_s, shift[7:1]};
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid   <= 1'b0;
            o_overrun <= 1'b0;
        end else begin
            o_overrun <= 1'b0;
            if (stop_ok) begin
                if (o_valid && !i_ready) o_overrun <= 1'b1;  // Held byte wins
                else o_valid <= 1'b1;
            end else if (o_valid && i_ready) begin
                o_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (stop_ok && !(o_valid && !i_ready)) o_data <= shift;
    end

    // Held byte stays offered until taken
    valid_held: assert property (@(posedge i_clk) disable iff (i_rst)
        o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

// File: verilog.f
+incdir+common
common/term_pkg.sv
common/vram_pkg.sv
uart/uart_rx.sv
logic/btn_toggle.sv
vram/vram.sv
control/scroll_engine.sv
control/term_control.sv
logic/term_core.sv
tests/tb_term_core.sv

// File: vram/vram.sv
`include "term_settings.svh"

module vram
    import term_pkg::*;
    import vram_pkg::*;
(
    input  logic       i_clk,
    input  vram_port_s i_port,        // Controller or scroll engine
    output char_t      o_rdata,       // One clock after a read
    input  vram_addr_u i_scan_addr,   // Renderer side
    output char_t      o_scan_data
);
    localparam int DEPTH = 1 << $bits(vram_addr_u);   // 2048 cells

    char_t mem [0:DEPTH-1];

    always_ff @(posedge i_clk) begin
        if (i_port.en) begin
            if (i_port.we) begin
                mem[i_port.addr.flat] <= i_port.wdata;
                o_rdata <= i_port.wdata;              // Write-first
            end else begin
                o_rdata <= mem[i_port.addr.flat];
            end
        end
    end

    // Scan side reads every clock
    always_ff @(posedge i_clk) begin
        o_scan_data <= mem[i_scan_addr.flat];
    end

    // Nobody writes below the visible screen
    row_in_screen: assert property (@(posedge i_clk)
        i_port.en && i_port.we |-> i_port.addr.rc.row < 5'(`TERM_ROWS));

endmodule
